// ==== hw/vwrite_macros.svh ====
`ifndef VWRITE_MACROS_SVH
`define VWRITE_MACROS_SVH

// memory address width, 1024 words
`define VW_ADDR_W 10

// one memory and databus word
`define VW_DATA_W 32

// period and duty counters
`define VW_PERIOD_W 8

// burst length on the databus
`define VW_LEN_W 8

// start delay counter
`define VW_DELAY_W 7

`endif

// ==== hw/addrgen_pkg.sv ====
`include "vwrite_macros.svh"

package addrgen_pkg;

   // memory address, also used for iteration counts and strides
   typedef logic [`VW_ADDR_W-1:0] addr_t;

   // period or duty count
   typedef logic [`VW_PERIOD_W-1:0] period_t;

   // start delay count
   typedef logic [`VW_DELAY_W-1:0] delay_t;

   // generator FSM
   typedef enum logic [1:0] {
      AG_IDLE,
      AG_DELAY,
      AG_RUN
   } addrgen_state_e;

endpackage

// ==== hw/databus_pkg.sv ====
`include "vwrite_macros.svh"

package databus_pkg;

   typedef logic [`VW_DATA_W-1:0] bus_data_t;

   // one strobe per byte lane
   typedef logic [`VW_DATA_W/8-1:0] bus_strb_t;

   typedef logic [`VW_LEN_W-1:0] burst_len_t;

   // where the next beat lives: memory output or local buffer
   typedef enum logic [1:0] {
      RD_EMPTY,
      RD_WAIT_DATA,
      RD_FULL
   } reader_state_e;

endpackage

// ==== hw/address_gen.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module address_gen (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  addrgen_pkg::addr_t   start_i,
   input  addrgen_pkg::period_t per_i,
   input  addrgen_pkg::period_t duty_i,
   input  addrgen_pkg::addr_t   incr_i,
   input  addrgen_pkg::addr_t   iter_i,
   input  addrgen_pkg::addr_t   shift_i,
   input  addrgen_pkg::addr_t   iter2_i,
   input  addrgen_pkg::addr_t   shift2_i,
   input  addrgen_pkg::delay_t  delay_i,
   input  logic                ready_i,
   output logic                valid_o,
   output addrgen_pkg::addr_t   addr_o,
   output logic                done_o
);
   import addrgen_pkg::*;

   addrgen_state_e state;
   delay_t         delay_cnt;
   period_t        per_cnt;
   addr_t          iter_cnt;
   addr_t          iter2_cnt;
   addr_t          addr;
   addr_t          outer_base;
   logic           advance;
   logic           last_per;
   logic           last_iter;
   logic           last_outer;

   // only the first duty cycles of each period carry an address
   assign valid_o = (state == AG_RUN) && (per_cnt < duty_i);
   assign addr_o  = addr;

   // hold everything while an address waits for its consumer
   assign advance = (state == AG_RUN) && (ready_i || !valid_o);

   assign last_per   = (per_cnt == per_i - 1'b1);
   assign last_iter  = (iter_cnt == iter_i - 1'b1);
   // zero outer iterations behave as one
   assign last_outer = (iter2_i == '0) || (iter2_cnt == iter2_i - 1'b1);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= AG_IDLE;
         done_o    <= 1'b1;
         delay_cnt <= '0;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         iter2_cnt <= '0;
      end else if (run_i) begin
         delay_cnt <= delay_i;
         per_cnt   <= '0;
         iter_cnt  <= '0;
         iter2_cnt <= '0;
         // nothing to generate, finish right away
         done_o    <= (iter_i == '0);
         if (iter_i == '0) begin
            state <= AG_IDLE;
         end else if (delay_i == '0) begin
            state <= AG_RUN;
         end else begin
            state <= AG_DELAY;
         end
      end else begin
         case (state)
            AG_DELAY: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == delay_t'(1)) begin
                  state <= AG_RUN;
               end
            end
            AG_RUN: begin
               if (advance) begin
                  if (!last_per) begin
                     per_cnt <= per_cnt + 1'b1;
                  end else begin
                     per_cnt <= '0;
                     if (!last_iter) begin
                        iter_cnt <= iter_cnt + 1'b1;
                     end else begin
                        iter_cnt <= '0;
                        if (!last_outer) begin
                           iter2_cnt <= iter2_cnt + 1'b1;
                        end else begin
                           state  <= AG_IDLE;
                           done_o <= 1'b1;
                        end
                     end
                  end
               end
            end
            default: begin
            end
         endcase
      end
   end

   // at the end of a period addr already holds base + (per-1)*incr
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr       <= start_i;
         outer_base <= start_i;
      end else if (advance) begin
         if (!last_per) begin
            addr <= addr + incr_i;
         end else if (!last_iter) begin
            addr <= addr + shift_i;
         end else if (!last_outer) begin
            addr       <= outer_base + shift2_i;
            outer_base <= outer_base + shift2_i;
         end
      end
   end

endmodule

// ==== hw/memory_reader.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module memory_reader (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   s_valid_i,
   input  addrgen_pkg::addr_t     s_addr_i,
   output logic                   s_ready_o,
   input  logic                   m_ready_i,
   output logic                   m_valid_o,
   output databus_pkg::bus_data_t m_data_o,
   output logic                   mem_enable_o,
   output addrgen_pkg::addr_t     mem_addr_o,
   input  databus_pkg::bus_data_t mem_data_i
);
   import databus_pkg::*;

   reader_state_e state;
   bus_data_t     held_data;
   logic          accept;

   assign m_valid_o = (state != RD_EMPTY);
   assign m_data_o  = (state == RD_FULL) ? held_data : mem_data_i;

   // room for a new word when empty or when the current one leaves now
   assign s_ready_o = (state == RD_EMPTY) || m_ready_i;
   assign accept    = s_valid_i && s_ready_o;

   assign mem_enable_o = accept;
   assign mem_addr_o   = s_addr_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state <= RD_EMPTY;
      end else begin
         case (state)
            RD_EMPTY: begin
               if (accept) begin
                  state <= RD_WAIT_DATA;
               end
            end
            RD_WAIT_DATA: begin
               if (!m_ready_i) begin
                  state <= RD_FULL;
               end else if (!accept) begin
                  state <= RD_EMPTY;
               end
            end
            RD_FULL: begin
               if (m_ready_i) begin
                  state <= accept ? RD_WAIT_DATA : RD_EMPTY;
               end
            end
            default: begin
               state <= RD_EMPTY;
            end
         endcase
      end
   end

   // park the memory word when the bus stalls
   always_ff @(posedge clk) begin
      if (state == RD_WAIT_DATA && !m_ready_i) begin
         held_data <= mem_data_i;
      end
   end

endmodule

// ==== hw/dual_port_mem.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module dual_port_mem (
   input  logic                   clk,
   input  logic                   wr_en_i,
   input  logic [`VW_ADDR_W-1:0]  wr_addr_i,
   input  databus_pkg::bus_data_t wr_data_i,
   input  logic                   rd_en_i,
   input  logic [`VW_ADDR_W-1:0]  rd_addr_i,
   output databus_pkg::bus_data_t rd_data_o
);
   import databus_pkg::*;

   bus_data_t mem [0:(1 << `VW_ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   // registered read, output holds between enables
   always_ff @(posedge clk) begin
      if (rd_en_i) begin
         rd_data_o <= mem[rd_addr_i];
      end
   end

endmodule

// ==== hw/vwrite.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module vwrite (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   input  logic                    running_i,
   input  logic                    ping_pong_i,
   input  databus_pkg::bus_data_t  data_i,
   input  addrgen_pkg::addr_t      st_start_i,
   input  addrgen_pkg::period_t    st_per_i,
   input  addrgen_pkg::period_t    st_duty_i,
   input  addrgen_pkg::addr_t      st_incr_i,
   input  addrgen_pkg::addr_t      st_iter_i,
   input  addrgen_pkg::addr_t      st_shift_i,
   input  addrgen_pkg::addr_t      st_iter2_i,
   input  addrgen_pkg::addr_t      st_shift2_i,
   input  addrgen_pkg::delay_t     st_delay_i,
   input  addrgen_pkg::period_t    wr_per_i,
   input  addrgen_pkg::period_t    wr_duty_i,
   input  addrgen_pkg::addr_t      wr_incr_i,
   input  addrgen_pkg::addr_t      wr_iter_i,
   input  addrgen_pkg::addr_t      wr_shift_i,
   input  databus_pkg::burst_len_t wr_length_i,
   input  logic                    wr_enabled_i,
   // bus address is one word wide
   input  databus_pkg::bus_data_t  ext_addr_i,
   input  logic                    db_ready_i,
   input  logic                    db_last_i,
   input  databus_pkg::bus_data_t  mem_rd_data_i,
   output logic                    done_o,
   output logic                    db_valid_o,
   output databus_pkg::bus_data_t  db_addr_o,
   output databus_pkg::bus_data_t  db_wdata_o,
   output databus_pkg::bus_strb_t  db_wstrb_o,
   output databus_pkg::burst_len_t db_len_o,
   output logic                    mem_wr_en_o,
   output addrgen_pkg::addr_t      mem_wr_addr_o,
   output databus_pkg::bus_data_t  mem_wr_data_o,
   output logic                    mem_rd_en_o,
   output addrgen_pkg::addr_t      mem_rd_addr_o
);
   import addrgen_pkg::*;

   logic  pp_state;
   logic  store_done;
   logic  write_done;
   logic  store_gen_done;
   logic  store_valid;
   addr_t store_addr;
   logic  rd_gen_valid;
   logic  rd_gen_ready;
   addr_t rd_gen_addr;
   addr_t rd_addr;
   logic  rd_m_valid;

   assign db_addr_o  = ext_addr_i;
   assign db_wstrb_o = '1;
   assign db_len_o   = wr_length_i;

   // halves swap on every run in ping-pong mode
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         pp_state <= 1'b0;
      end else if (run_i) begin
         pp_state <= ping_pong_i ? !pp_state : 1'b0;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         store_done <= 1'b1;
         write_done <= 1'b1;
      end else if (run_i) begin
         store_done <= 1'b0;
         write_done <= !wr_enabled_i;
      end else if (running_i) begin
         store_done <= store_gen_done;
         if (db_valid_o && db_ready_i && db_last_i) begin
            write_done <= 1'b1;
         end
      end
   end

   assign done_o = store_done && write_done;

   // store side never stalls, the stream keeps coming
   address_gen store_gen (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i),
      .start_i  (st_start_i),
      .per_i    (st_per_i),
      .duty_i   (st_duty_i),
      .incr_i   (st_incr_i),
      .iter_i   (st_iter_i),
      .shift_i  (st_shift_i),
      .iter2_i  (st_iter2_i),
      .shift2_i (st_shift2_i),
      .delay_i  (st_delay_i),
      .ready_i  (1'b1),
      .valid_o  (store_valid),
      .addr_o   (store_addr),
      .done_o   (store_gen_done)
   );

   assign mem_wr_en_o   = store_valid;
   assign mem_wr_addr_o = {ping_pong_i ? pp_state : store_addr[`VW_ADDR_W-1],
                           store_addr[`VW_ADDR_W-2:0]};
   assign mem_wr_data_o = data_i;

   // single inner pattern from address zero
   address_gen write_gen (
      .clk      (clk),
      .rst      (rst),
      .run_i    (run_i && wr_enabled_i),
      .start_i  (addr_t'(0)),
      .per_i    (wr_per_i),
      .duty_i   (wr_duty_i),
      .incr_i   (wr_incr_i),
      .iter_i   (wr_iter_i),
      .shift_i  (wr_shift_i),
      .iter2_i  (addr_t'(1)),
      .shift2_i (addr_t'(0)),
      .delay_i  (delay_t'(0)),
      .ready_i  (rd_gen_ready),
      .valid_o  (rd_gen_valid),
      .addr_o   (rd_gen_addr),
      .done_o   ()
   );

   // read from the half the store side is not using
   assign rd_addr = {ping_pong_i ? !pp_state : rd_gen_addr[`VW_ADDR_W-1],
                     rd_gen_addr[`VW_ADDR_W-2:0]};

   memory_reader reader (
      .clk          (clk),
      .rst          (rst),
      .s_valid_i    (rd_gen_valid),
      .s_addr_i     (rd_addr),
      .s_ready_o    (rd_gen_ready),
      .m_ready_i    (db_ready_i),
      .m_valid_o    (rd_m_valid),
      .m_data_o     (db_wdata_o),
      .mem_enable_o (mem_rd_en_o),
      .mem_addr_o   (mem_rd_addr_o),
      .mem_data_i   (mem_rd_data_i)
   );

   assign db_valid_o = rd_m_valid && !write_done;

endmodule

// ==== hw/vwrite_top.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module vwrite_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run_i,
   input  logic                    running_i,
   input  addrgen_pkg::addr_t      st_start_i,
   input  addrgen_pkg::period_t    st_per_i,
   input  addrgen_pkg::period_t    st_duty_i,
   input  addrgen_pkg::addr_t      st_incr_i,
   input  addrgen_pkg::addr_t      st_iter_i,
   input  addrgen_pkg::addr_t      st_shift_i,
   input  addrgen_pkg::addr_t      st_iter2_i,
   input  addrgen_pkg::addr_t      st_shift2_i,
   input  addrgen_pkg::delay_t     st_delay_i,
   input  addrgen_pkg::period_t    wr_per_i,
   input  addrgen_pkg::period_t    wr_duty_i,
   input  addrgen_pkg::addr_t      wr_incr_i,
   input  addrgen_pkg::addr_t      wr_iter_i,
   input  addrgen_pkg::addr_t      wr_shift_i,
   input  databus_pkg::burst_len_t wr_length_i,
   input  logic                    wr_enabled_i,
   input  databus_pkg::bus_data_t  ext_addr_i,
   input  logic                    ping_pong_i,
   input  databus_pkg::bus_data_t  data_i,
   output logic                    done_o,
   output logic                    db_valid_o,
   output databus_pkg::bus_data_t  db_addr_o,
   output databus_pkg::bus_data_t  db_wdata_o,
   output databus_pkg::bus_strb_t  db_wstrb_o,
   output databus_pkg::burst_len_t db_len_o,
   input  logic                    db_ready_i,
   input  logic                    db_last_i
);
   import databus_pkg::*;

   logic                  mem_wr_en;
   logic [`VW_ADDR_W-1:0] mem_wr_addr;
   bus_data_t             mem_wr_data;
   logic                  mem_rd_en;
   logic [`VW_ADDR_W-1:0] mem_rd_addr;
   bus_data_t             mem_rd_data;

   vwrite vwrite_i (
      .clk           (clk),
      .rst           (rst),
      .run_i         (run_i),
      .running_i     (running_i),
      .ping_pong_i   (ping_pong_i),
      .data_i        (data_i),
      .st_start_i    (st_start_i),
      .st_per_i      (st_per_i),
      .st_duty_i     (st_duty_i),
      .st_incr_i     (st_incr_i),
      .st_iter_i     (st_iter_i),
      .st_shift_i    (st_shift_i),
      .st_iter2_i    (st_iter2_i),
      .st_shift2_i   (st_shift2_i),
      .st_delay_i    (st_delay_i),
      .wr_per_i      (wr_per_i),
      .wr_duty_i     (wr_duty_i),
      .wr_incr_i     (wr_incr_i),
      .wr_iter_i     (wr_iter_i),
      .wr_shift_i    (wr_shift_i),
      .wr_length_i   (wr_length_i),
      .wr_enabled_i  (wr_enabled_i),
      .ext_addr_i    (ext_addr_i),
      .db_ready_i    (db_ready_i),
      .db_last_i     (db_last_i),
      .mem_rd_data_i (mem_rd_data),
      .done_o        (done_o),
      .db_valid_o    (db_valid_o),
      .db_addr_o     (db_addr_o),
      .db_wdata_o    (db_wdata_o),
      .db_wstrb_o    (db_wstrb_o),
      .db_len_o      (db_len_o),
      .mem_wr_en_o   (mem_wr_en),
      .mem_wr_addr_o (mem_wr_addr),
      .mem_wr_data_o (mem_wr_data),
      .mem_rd_en_o   (mem_rd_en),
      .mem_rd_addr_o (mem_rd_addr)
   );

   // store port writes, reader port reads
   dual_port_mem mem_i (
      .clk       (clk),
      .wr_en_i   (mem_wr_en),
      .wr_addr_i (mem_wr_addr),
      .wr_data_i (mem_wr_data),
      .rd_en_i   (mem_rd_en),
      .rd_addr_i (mem_rd_addr),
      .rd_data_o (mem_rd_data)
   );

endmodule

// ==== sim/vwrite_tb.sv ====
`timescale 1ns/1ps
`include "vwrite_macros.svh"

module vwrite_tb;
   import addrgen_pkg::*;
   import databus_pkg::*;

   // five runs of under 100 cycles each, with generous margin
   localparam int MAX_CYCLES = 4000;

   logic clk = 1'b0, rst = 1'b1, run_i = 1'b0, running_i = 1'b0;
   addr_t st_start_i = '0, st_incr_i = '0, st_iter_i = '0, st_shift_i = '0;
   addr_t st_iter2_i = '0, st_shift2_i = '0;
   period_t st_per_i = '0, st_duty_i = '0, wr_per_i = '0, wr_duty_i = '0;
   delay_t st_delay_i = '0;
   addr_t wr_incr_i = '0, wr_iter_i = '0, wr_shift_i = '0;
   burst_len_t wr_length_i = '0;
   logic wr_enabled_i = 1'b0, ping_pong_i = 1'b0;
   bus_data_t ext_addr_i = 32'h8000_0000, data_i = '0;
   logic db_ready_i = 1'b0, db_last_i = 1'b0;
   logic done_o, db_valid_o;
   bus_data_t db_addr_o, db_wdata_o;
   bus_strb_t db_wstrb_o;
   burst_len_t db_len_o;

   integer seed = 32'ha0d1;
   int cycles = 0, errors = 0, tests_run = 0, tests_failed = 0;
   int since_run = 0, beat_cnt = 0, slave_cnt = 0, exp_len = 0, store_end = 0;
   int ready_pct = 75;
   logic in_run = 1'b0, pp_model = 1'b0;
   logic prev_valid = 1'b0, prev_ready = 1'b0;
   bus_data_t prev_data;
   string cur_test = "reset";
   bus_data_t exp_q[$];
   bus_data_t shadow [0:(1 << `VW_ADDR_W)-1];
   addr_t pat_addr_q[$];
   int pat_cyc_q[$];

   vwrite_top dut_i (.*);

   always #5 clk = !clk;

   task automatic report_mismatch(string what, bus_data_t exp_v, bus_data_t act_v);
      $display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
      errors++;
   endtask

   task automatic report_fail(string msg);
      $display("[%s] %s", cur_test, msg);
      errors++;
   endtask

   // two-level loop walk that lists valid addresses and their cycle index
   task automatic gen_pattern(addr_t start, int per, int duty, addr_t incr, int iter,
                              addr_t shift, int iter2, addr_t shift2);
      addr_t obase, base;
      int c;
      pat_addr_q.delete();
      pat_cyc_q.delete();
      obase = start;
      c = 0;
      for (int o = 0; o < ((iter2 == 0) ? 1 : iter2); o++) begin
         base = obase;
         for (int i = 0; i < iter; i++) begin
            for (int j = 0; j < per; j++) begin
               if (j < duty) begin
                  pat_addr_q.push_back(base + addr_t'(j) * incr);
                  pat_cyc_q.push_back(c);
               end
               c++;
            end
            base = base + addr_t'(per - 1) * incr + shift;
         end
         obase = obase + shift2;
      end
   endtask

   function automatic addr_t map_half(addr_t a, logic pp, logic half);
      return pp ? {half, a[`VW_ADDR_W-2:0]} : a;
   endfunction

   task automatic tick();
      @(posedge clk);
      data_i <= data_i + 1;
      run_i  <= 1'b0;
   endtask

   task automatic do_run(string name, logic pp, logic wr_en, int s_iter, int delay,
                         logic [15:0] tag);
      int err0;
      int len;
      logic half;
      addr_t st_a[$];
      bus_data_t st_d[$];
      cur_test = name;
      err0 = errors;
      half = pp ? !pp_model : 1'b0;
      exp_q.delete();
      if (wr_en) begin
         gen_pattern('0, 3, 3, 1, 6, 3, 1, 0);
         foreach (pat_addr_q[k]) exp_q.push_back(shadow[map_half(pat_addr_q[k], pp, !half)]);
      end
      len = exp_q.size();
      gen_pattern('0, 4, 3, 1, s_iter, 2, 2, 15);
      foreach (pat_addr_q[k]) begin
         st_a.push_back(map_half(pat_addr_q[k], pp, half));
         st_d.push_back({tag, 16'h0} + bus_data_t'(delay + 1 + pat_cyc_q[k]));
      end
      @(posedge clk);
      run_i <= 1'b1;
      data_i <= {tag, 16'h0};
      ext_addr_i <= {tag, 16'h4000};
      ping_pong_i <= pp;
      wr_enabled_i <= wr_en;
      wr_length_i <= burst_len_t'(len);
      st_iter_i <= addr_t'(s_iter);
      st_delay_i <= delay_t'(delay);
      pp_model = half;
      tick();
      // the monitor restarts its counters on this edge
      exp_len = len;
      store_end = (s_iter == 0) ? 0 : delay + 2 * s_iter * 4 + 1;
      in_run = 1'b1;
      tick();
      while (!done_o) tick();
      repeat (4) tick();
      assert (beat_cnt == exp_len) else report_mismatch("beat count", exp_len, beat_cnt);
      foreach (st_a[k]) shadow[st_a[k]] = st_d[k];
      tests_run++;
      if (errors != err0) tests_failed++;
      $display("%-12s %s", name, (errors == err0) ? "ok" : "FAILED");
   endtask

   // databus slave that raises last with ready on the final beat
   always @(posedge clk) begin
      int n;
      logic r;
      n = (run_i) ? 0 : slave_cnt + ((db_valid_o && db_ready_i) ? 1 : 0);
      slave_cnt = n;
      r = ($unsigned($random(seed)) % 100) < ready_pct;
      db_ready_i <= r;
      db_last_i  <= r && (n == int'(wr_length_i) - 1);
   end

   // bus and done monitor
   always @(posedge clk) begin
      if (!rst) begin
         if (!in_run) begin
            assert (done_o && !db_valid_o) else report_fail("busy before the first run");
         end
         if (prev_valid && !prev_ready) begin
            assert (db_valid_o) else report_fail("valid dropped during a stall");
            assert (db_wdata_o == prev_data) else
               report_mismatch("stalled wdata", prev_data, db_wdata_o);
         end
         if (run_i) begin
            since_run = 0;
            beat_cnt = 0;
         end else begin
            since_run++;
            if (in_run && done_o) begin
               assert (beat_cnt == exp_len && since_run >= store_end && !db_valid_o) else
                  report_fail("done high while beats or stores remain");
            end
            if (db_valid_o) begin
               assert (db_addr_o == ext_addr_i) else
                  report_mismatch("bus address", ext_addr_i, db_addr_o);
               assert (db_wstrb_o == '1) else
                  report_mismatch("write strobes", {(`VW_DATA_W/8){1'b1}}, db_wstrb_o);
               assert (db_len_o == burst_len_t'(exp_len)) else
                  report_mismatch("burst length", exp_len, db_len_o);
            end
            if (db_valid_o && db_ready_i) begin
               assert (beat_cnt < exp_len) else report_fail("unexpected extra beat");
               if (beat_cnt < exp_len) begin
                  assert (db_wdata_o == exp_q[beat_cnt]) else
                     report_mismatch("beat data", exp_q[beat_cnt], db_wdata_o);
               end
               beat_cnt++;
            end
         end
      end
      prev_valid <= db_valid_o;
      prev_ready <= db_ready_i;
      prev_data  <= db_wdata_o;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

   initial begin
      st_per_i <= 8'd4;
      st_duty_i <= 8'd3;
      st_incr_i <= 10'd1;
      st_shift_i <= 10'd2;
      st_iter2_i <= 10'd2;
      st_shift2_i <= 10'd15;
      wr_per_i <= 8'd3;
      wr_duty_i <= 8'd3;
      wr_incr_i <= 10'd1;
      wr_iter_i <= 10'd6;
      wr_shift_i <= 10'd3;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      running_i <= 1'b1;
      repeat (5) tick();
      tests_run++;
      $display("%-12s %s", "reset", (errors == 0) ? "ok" : "FAILED");
      if (errors != 0) tests_failed++;
      do_run("store_only", 1'b0, 1'b0, 3, 3, 16'h0001);
      do_run("write_back", 1'b0, 1'b1, 0, 0, 16'h0002);
      do_run("pingpong_a", 1'b1, 1'b1, 3, 0, 16'h0003);
      do_run("pingpong_b", 1'b1, 1'b1, 3, 2, 16'h0004);
      ready_pct = 40;
      do_run("backpressure", 1'b1, 1'b1, 3, 1, 16'h0005);
      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

// ==== vwrite.f ====
+incdir+hw
hw/addrgen_pkg.sv
hw/databus_pkg.sv
hw/address_gen.sv
hw/memory_reader.sv
hw/dual_port_mem.sv
hw/vwrite.sv
hw/vwrite_top.sv
sim/vwrite_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := vwrite_tb
FILELIST  := vwrite.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(wildcard hw/*.sv hw/*.svh sim/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
